// File: vid_wr_params.svh
// ############################
// video write arbiter sizes
// channel count, word and address widths,
// burst length and frame area size
// ############################

`ifndef VID_WR_PARAMS_SVH
`define VID_WR_PARAMS_SVH

// camera channels served in round-robin order
`define VW_NUM_CH       5

`define VW_WORD_W       64      // pixel word
`define VW_BUF_AW       5       // 32 words per line buffer
`define VW_DDR_AW       28      // DDR word address

`define VW_BURST_LEN    16      // beats per burst

// one ping or pong area, in words
`define VW_FRAME_WORDS  40960

`endif

// File: vid_wr_pkg.sv
// ############################
// video write arbiter types
// index, address and word types, sequencer
// states and the write channel structs
// ############################

`default_nettype none

`include "vid_wr_params.svh"

package vid_wr_pkg;

    typedef logic [2:0]               ch_idx_t;     // channel number
    typedef logic [`VW_BUF_AW-1:0]    buf_addr_t;
    typedef logic [`VW_DDR_AW-1:0]    ddr_addr_t;
    typedef logic [`VW_WORD_W-1:0]    word_t;
    typedef logic [4:0]               beat_cnt_t;   // 0..16

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        ADDR,
        DATA
    } seq_state_e;

    // write address request
    typedef struct packed {
        logic      valid;
        ddr_addr_t addr;
    } aw_req_t;

    // one write data beat
    typedef struct packed {
        logic  valid;
        logic  last;
        word_t data;
    } w_beat_t;

endpackage

`default_nettype wire

// File: frame_addr_gen.sv
// ############################
// frame address generator
// per-channel ping-pong bank and burst
// offset, gives the granted burst's address
// ############################

`timescale 1ns/10ps
`default_nettype none

`include "vid_wr_params.svh"

module frame_addr_gen import vid_wr_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire ch_idx_t               grant,
    input  wire logic                  start,
    input  wire logic                  issue,
    input  wire logic                  done,
    input  wire logic [`VW_NUM_CH-1:0] frame_end,
    output ddr_addr_t                  burst_addr
);

    logic [`VW_NUM_CH-1:0] bank;        // ping-pong area select
    logic [`VW_NUM_CH-1:0] pend;        // frame end seen during own burst
    logic [`VW_NUM_CH-1:0] sel;         // one-hot of grant
    ddr_addr_t             offset [`VW_NUM_CH];
    logic                  busy;
    logic                  busy_now;
    ddr_addr_t             base;
    ddr_addr_t             bank_off;

    // granted channel counts as busy from start through done
    assign busy_now = start | busy;

    always_comb begin
        for (int c = 0; c < `VW_NUM_CH; c++) begin
            sel[c] = (grant == ch_idx_t'(c));
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bank <= '0;
            pend <= '0;
            for (int c = 0; c < `VW_NUM_CH; c++) begin
                offset[c] <= '0;
            end
        end else begin
            for (int c = 0; c < `VW_NUM_CH; c++) begin
                if (done && sel[c] && (pend[c] || frame_end[c])) begin
                    offset[c] <= '0;                // switch area at burst end
                    bank[c]   <= ~bank[c];
                    pend[c]   <= 1'b0;
                end else if (frame_end[c] && busy_now && sel[c]) begin
                    pend[c] <= 1'b1;                // hold until done
                end else if (frame_end[c]) begin
                    offset[c] <= '0;
                    bank[c]   <= ~bank[c];
                end else if (issue && sel[c]) begin
                    offset[c] <= offset[c] + ddr_addr_t'(`VW_BURST_LEN);
                end
            end
        end
    end

    // channel base plus area base
    assign base     = ddr_addr_t'(grant * (2 * `VW_FRAME_WORDS));
    assign bank_off = bank[grant] ? ddr_addr_t'(`VW_FRAME_WORDS) : '0;

    // one cycle after start, stable until issue
    always_ff @(posedge clk) begin
        if (start) begin
            burst_addr <= base + bank_off + offset[grant];
        end
    end

endmodule

`default_nettype wire

// File: line_buf_reader.sv
// ############################
// line buffer reader
// wrapping read pointers per channel and a
// two-entry skid buffer for burst beats
// ############################

`timescale 1ns/10ps
`default_nettype none

`include "vid_wr_params.svh"

module line_buf_reader import vid_wr_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire ch_idx_t               grant,
    input  wire logic                  start,
    output logic [`VW_NUM_CH-1:0]      buf_rd_en,
    output buf_addr_t                  buf_rd_addr [`VW_NUM_CH],
    input  wire word_t                 buf_rd_data [`VW_NUM_CH],
    output logic                       beat_valid,
    output word_t                      beat_data,
    input  wire logic                  beat_take
);

    buf_addr_t  rd_ptr [`VW_NUM_CH];     // survives across bursts
    beat_cnt_t  reads_left;
    logic       rd_go;
    logic       rd_pend;                 // word returns this cycle
    logic [2:0] fill;
    logic       room;

    // skid buffer
    word_t      skid [2];
    logic       wr_sel;
    logic       rd_sel;
    logic [1:0] cnt;

    // words held or in flight, less the one leaving now
    assign fill = {1'b0, cnt} + {2'b0, rd_pend};
    assign room = fill < (3'd2 + {2'b0, beat_take});

    assign rd_go = (start || reads_left != '0) && room;

    always_comb begin
        for (int c = 0; c < `VW_NUM_CH; c++) begin
            buf_rd_en[c]   = rd_go && (grant == ch_idx_t'(c));
            buf_rd_addr[c] = rd_ptr[c];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int c = 0; c < `VW_NUM_CH; c++) begin
                rd_ptr[c] <= '0;
            end
        end else begin
            for (int c = 0; c < `VW_NUM_CH; c++) begin
                if (buf_rd_en[c]) begin
                    rd_ptr[c] <= rd_ptr[c] + 1'b1;   // wraps at 32
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            reads_left <= '0;
            rd_pend    <= 1'b0;
        end else begin
            rd_pend <= rd_go;
            if (start) begin
                reads_left <= beat_cnt_t'(`VW_BURST_LEN) - {4'b0, rd_go};
            end else if (rd_go) begin
                reads_left <= reads_left - 1'b1;
            end
        end
    end

    // skid pointers and fill level
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_sel <= 1'b0;
            rd_sel <= 1'b0;
            cnt    <= '0;
        end else begin
            if (rd_pend) begin
                wr_sel <= ~wr_sel;
            end
            if (beat_take) begin
                rd_sel <= ~rd_sel;
            end
            cnt <= cnt + {1'b0, rd_pend} - {1'b0, beat_take};
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pend) begin
            skid[wr_sel] <= buf_rd_data[grant];
        end
    end

    assign beat_valid = (cnt != '0);
    assign beat_data  = skid[rd_sel];

endmodule

`default_nettype wire

// File: burst_sequencer.sv
// ############################
// burst sequencer
// round-robin scan, address and data
// handshakes, beat count and last
// ############################

`timescale 1ns/10ps
`default_nettype none

`include "vid_wr_params.svh"

module burst_sequencer import vid_wr_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [`VW_NUM_CH-1:0] buf_ready,
    output ch_idx_t                    grant,
    output logic                       start,
    output logic                       issue,
    output logic                       done,
    input  wire ddr_addr_t             burst_addr,
    input  wire logic                  beat_valid,
    input  wire word_t                 beat_data,
    output logic                       beat_take,
    output aw_req_t                    aw,
    input  wire logic                  aw_ready,
    output w_beat_t                    w,
    input  wire logic                  w_ready
);

    seq_state_e state;
    ch_idx_t    scan_ch;
    beat_cnt_t  beat_cnt;
    logic       aw_valid;
    logic       last_beat;

    function automatic ch_idx_t next_ch(input ch_idx_t ch);
        if (ch == ch_idx_t'(`VW_NUM_CH - 1)) begin
            return '0;
        end
        return ch + 1'b1;
    endfunction

    assign last_beat = (beat_cnt == beat_cnt_t'(`VW_BURST_LEN - 1));

    always_comb begin
        aw.valid = aw_valid;
        aw.addr  = burst_addr;                   // held by the generator until issue
        w.valid  = (state == DATA) && beat_valid;
        w.last   = last_beat;
        w.data   = beat_data;
    end

    assign issue     = aw.valid && aw_ready;
    assign beat_take = w.valid && w_ready;
    assign done      = beat_take && last_beat;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= IDLE;
            scan_ch <= '0;
            grant   <= '0;
            start   <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                IDLE: begin
                    if (|buf_ready) begin
                        state <= SCAN;
                    end
                end
                SCAN: begin
                    if (buf_ready[scan_ch]) begin
                        grant <= scan_ch;
                        start <= 1'b1;
                        state <= ADDR;
                    end else begin
                        scan_ch <= next_ch(scan_ch);   // one step per cycle
                    end
                end
                ADDR: begin
                    if (issue) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (done) begin
                        scan_ch <= next_ch(grant);
                        state   <= SCAN;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // aw valid rises the cycle after start, address is ready by then
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            aw_valid <= 1'b0;
        end else if (start) begin
            aw_valid <= 1'b1;
        end else if (issue) begin
            aw_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            beat_cnt <= '0;
        end else if (done) begin
            beat_cnt <= '0;
        end else if (beat_take) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: vid_wr_top.sv
// ############################
// video write arbiter top
// address generator and buffer reader
// joined by the burst sequencer
// ############################

`timescale 1ns/10ps
`default_nettype none

`include "vid_wr_params.svh"

module vid_wr_top import vid_wr_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [`VW_NUM_CH-1:0] buf_ready,
    output logic [`VW_NUM_CH-1:0]      buf_rd_en,
    output buf_addr_t                  buf_rd_addr [`VW_NUM_CH],
    input  wire word_t                 buf_rd_data [`VW_NUM_CH],
    input  wire logic [`VW_NUM_CH-1:0] frame_end,
    output aw_req_t                    aw,
    input  wire logic                  aw_ready,
    output w_beat_t                    w,
    input  wire logic                  w_ready
);

    ch_idx_t   grant;
    logic      start;
    logic      issue;
    logic      done;
    ddr_addr_t burst_addr;
    logic      beat_valid;
    word_t     beat_data;
    logic      beat_take;

    frame_addr_gen u_addr (
        .clk        (clk),
        .rst        (rst),
        .grant      (grant),
        .start      (start),
        .issue      (issue),
        .done       (done),
        .frame_end  (frame_end),
        .burst_addr (burst_addr)
    );

    line_buf_reader u_reader (
        .clk         (clk),
        .rst         (rst),
        .grant       (grant),
        .start       (start),
        .buf_rd_en   (buf_rd_en),
        .buf_rd_addr (buf_rd_addr),
        .buf_rd_data (buf_rd_data),
        .beat_valid  (beat_valid),
        .beat_data   (beat_data),
        .beat_take   (beat_take)
    );

    burst_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .buf_ready  (buf_ready),
        .grant      (grant),
        .start      (start),
        .issue      (issue),
        .done       (done),
        .burst_addr (burst_addr),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .beat_take  (beat_take),
        .aw         (aw),
        .aw_ready   (aw_ready),
        .w          (w),
        .w_ready    (w_ready)
    );

endmodule

`default_nettype wire

// File: tb_vid_wr.sv
// ##############################
// video write arbiter testbench
// buffer and DDR models, random stalls and
// frame ends, checked by concurrent assertions
// ##############################

`timescale 1ns/10ps
`default_nettype none

`include "vid_wr_params.svh"

module tb_vid_wr import vid_wr_pkg::*; ();

    localparam int BURSTS    = 60;
    localparam int WD_CYCLES = BURSTS * 40 + 10;

    logic                  clk       = 1'b0;
    logic                  rst       = 1'b0;
    logic [`VW_NUM_CH-1:0] buf_ready = '0;
    logic [`VW_NUM_CH-1:0] frame_end = '0;
    logic                  aw_ready  = 1'b0;
    logic                  w_ready   = 1'b0;
    word_t                 buf_rd_data [`VW_NUM_CH] = '{default: '0};
    logic [`VW_NUM_CH-1:0] buf_rd_en;
    buf_addr_t             buf_rd_addr [`VW_NUM_CH];
    aw_req_t               aw;
    w_beat_t               w;

    integer seed;
    int     errors;
    int     post_cyc;

    // reference model state
    ddr_addr_t             off_m [`VW_NUM_CH];
    buf_addr_t             ptr_m [`VW_NUM_CH];
    logic [`VW_NUM_CH-1:0] bank_m;
    logic [`VW_NUM_CH-1:0] pend_m;
    ch_idx_t               cur_ch;
    ch_idx_t               last_ch;
    logic                  in_burst;
    beat_cnt_t             beat_idx;
    int                    bursts;
    logic                  ready_seen;
    logic                  aw_hold;
    ddr_addr_t             aw_prev;
    logic                  w_hold;
    w_beat_t               w_prev;

    logic      aw_hs;
    logic      w_hs;
    logic      last_exp;
    logic      end_hs;
    ch_idx_t   exp_ch;
    ch_idx_t   aw_ch;
    ddr_addr_t exp_addr;
    word_t     exp_data;

    vid_wr_top dut (
        .clk         (clk),
        .rst         (rst),
        .buf_ready   (buf_ready),
        .buf_rd_en   (buf_rd_en),
        .buf_rd_addr (buf_rd_addr),
        .buf_rd_data (buf_rd_data),
        .frame_end   (frame_end),
        .aw          (aw),
        .aw_ready    (aw_ready),
        .w           (w),
        .w_ready     (w_ready)
    );

    always #50 clk = ~clk;

    function automatic word_t word_of(input ch_idx_t c, input buf_addr_t a);
        return {5'b0, c, 48'h0, 3'b0, a};           // channel on top, address low
    endfunction

    // first ready channel after the last one served
    function automatic ch_idx_t next_ready(input ch_idx_t last,
                                           input logic [`VW_NUM_CH-1:0] ready);
        int c;
        c = int'(last);
        for (int i = 0; i < `VW_NUM_CH; i++) begin
            c = (c + 1) % `VW_NUM_CH;
            if (ready[c]) begin
                return ch_idx_t'(c);
            end
        end
        return last;
    endfunction

    function automatic bit roll_percent(input int pct);
        return ({$random(seed)} % 100) < pct;
    endfunction

    function automatic logic [`VW_NUM_CH-1:0] pick_ready();
        logic [`VW_NUM_CH-1:0] r;
        r = `VW_NUM_CH'($random(seed));
        if (r == '0) begin
            r[0] = 1'b1;                            // never all idle
        end
        return r;
    endfunction

    assign aw_hs    = aw.valid && aw_ready;
    assign w_hs     = w.valid && w_ready;
    assign last_exp = (beat_idx == beat_cnt_t'(`VW_BURST_LEN - 1));
    assign end_hs   = w_hs && last_exp;
    assign exp_ch   = next_ready(last_ch, buf_ready);
    assign aw_ch    = ch_idx_t'(aw.addr / ddr_addr_t'(2 * `VW_FRAME_WORDS));
    assign exp_addr = ddr_addr_t'(exp_ch) * ddr_addr_t'(2 * `VW_FRAME_WORDS)
                    + (bank_m[exp_ch] ? ddr_addr_t'(`VW_FRAME_WORDS) : '0)
                    + off_m[exp_ch];
    assign exp_data = word_of(cur_ch, ptr_m[cur_ch]);

    // line buffers, one cycle read latency
    always @(posedge clk) begin
        for (int c = 0; c < `VW_NUM_CH; c++) begin
            if (buf_rd_en[c]) begin
                buf_rd_data[c] <= word_of(ch_idx_t'(c), buf_rd_addr[c]);
            end
        end
    end

    // DDR ready stalls, buffer levels and frame ends
    always @(posedge clk) begin
        logic busy_after;
        busy_after = (in_burst || aw_hs) && !end_hs;
        if (rst) begin
            post_cyc  <= post_cyc + 1;
            aw_ready  <= roll_percent(70);
            w_ready   <= roll_percent(70);
            frame_end <= '0;
            if (post_cyc == 5 || end_hs) begin
                buf_ready <= pick_ready();          // stable from one burst end to the next
            end
            if (busy_after && roll_percent(5)) begin
                frame_end[{$random(seed)} % `VW_NUM_CH] <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            for (int c = 0; c < `VW_NUM_CH; c++) begin
                off_m[c] <= '0;
                ptr_m[c] <= '0;
            end
            bank_m     <= '0;
            pend_m     <= '0;
            cur_ch     <= '0;
            last_ch    <= ch_idx_t'(`VW_NUM_CH - 1);
            in_burst   <= 1'b0;
            beat_idx   <= '0;
            bursts     <= 0;
            ready_seen <= 1'b0;
            aw_hold    <= 1'b0;
            w_hold     <= 1'b0;
        end else begin
            if (buf_ready != '0) begin
                ready_seen <= 1'b1;
            end
            aw_hold <= aw.valid && !aw_ready;
            aw_prev <= aw.addr;
            w_hold  <= w.valid && !w_ready;
            w_prev  <= w;
            if (aw_hs) begin
                cur_ch        <= exp_ch;
                last_ch       <= exp_ch;
                in_burst      <= 1'b1;
                off_m[exp_ch] <= off_m[exp_ch] + ddr_addr_t'(`VW_BURST_LEN);
            end
            if (w_hs) begin
                ptr_m[cur_ch] <= ptr_m[cur_ch] + 1'b1;   // wraps at 32
                beat_idx      <= beat_idx + 1'b1;
            end
            for (int c = 0; c < `VW_NUM_CH; c++) begin
                if (frame_end[c]) begin
                    if (in_burst && ch_idx_t'(c) == cur_ch) begin
                        pend_m[c] <= 1'b1;          // own burst, waits for its end
                    end else begin
                        off_m[c]  <= '0;
                        bank_m[c] <= ~bank_m[c];
                    end
                end
            end
            if (end_hs) begin
                in_burst <= 1'b0;
                beat_idx <= '0;
                bursts   <= bursts + 1;
                if (pend_m[cur_ch] || frame_end[cur_ch]) begin
                    off_m[cur_ch]  <= '0;
                    bank_m[cur_ch] <= ~bank_m[cur_ch];
                    pend_m[cur_ch] <= 1'b0;
                end
            end
        end
    end

    idle_quiet: assert property (@(posedge clk) disable iff (!rst)
        !ready_seen |-> (!aw.valid && !w.valid && buf_rd_en == '0))
        else begin
            errors++;
            $display("FAIL idle_quiet: expected 0 actual %b",
                     $sampled({aw.valid, w.valid, buf_rd_en}));
        end

    round_robin: assert property (@(posedge clk) disable iff (!rst)
        aw_hs |-> aw_ch == exp_ch)
        else begin
            errors++;
            $display("FAIL round_robin: expected %0d actual %0d",
                     $sampled(exp_ch), $sampled(aw_ch));
        end

    addr_rule: assert property (@(posedge clk) disable iff (!rst)
        aw_hs |-> aw.addr == exp_addr)
        else begin
            errors++;
            $display("FAIL addr_rule: expected %h actual %h",
                     $sampled(exp_addr), $sampled(aw.addr));
        end

    addr_order: assert property (@(posedge clk) disable iff (!rst)
        aw_hs |-> !in_burst)
        else begin
            errors++;
            $display("address accepted while the previous burst was still open");
        end

    beat_in_burst: assert property (@(posedge clk) disable iff (!rst)
        w_hs |-> in_burst)
        else begin
            errors++;
            $display("data beat accepted with no burst open");
        end

    last_flag: assert property (@(posedge clk) disable iff (!rst)
        w_hs |-> w.last == last_exp)
        else begin
            errors++;
            $display("FAIL last_flag: expected %b actual %b",
                     $sampled(last_exp), $sampled(w.last));
        end

    beat_data: assert property (@(posedge clk) disable iff (!rst)
        w_hs |-> w.data == exp_data)
        else begin
            errors++;
            $display("FAIL beat_data: expected %h actual %h",
                     $sampled(exp_data), $sampled(w.data));
        end

    aw_stable: assert property (@(posedge clk) disable iff (!rst)
        aw_hold |-> (aw.valid && aw.addr == aw_prev))
        else begin
            errors++;
            $display("FAIL aw_stable: expected %h actual %h",
                     $sampled(aw_prev), $sampled(aw.addr));
        end

    w_stable: assert property (@(posedge clk) disable iff (!rst)
        w_hold |-> (w.valid && w.data == w_prev.data && w.last == w_prev.last))
        else begin
            errors++;
            $display("FAIL w_stable: expected %h actual %h",
                     $sampled(w_prev), $sampled(w));
        end

    initial begin
        seed     = 64777;
        errors   = 0;
        post_cyc = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        while (bursts < BURSTS) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("timeout: only %0d of %0d bursts finished", bursts, BURSTS);
        $display("errors: %0d", errors + 1);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
vid_wr_pkg.sv
frame_addr_gen.sv
line_buf_reader.sv
burst_sequencer.sv
vid_wr_top.sv
tb_vid_wr.sv

// File: Makefile
# Verilator run of the video write arbiter testbench

TOP := tb_vid_wr

.PHONY: sim clean

# passes only when the log holds the pass line
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
